//--- hw/pipePkg.sv
// Datapath widths and ALU operation codes shared by the pipeline stages.
package pipePkg;

    localparam int WordWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int ImmWidth     = 16;

    typedef logic [WordWidth-1:0]    word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;
    typedef logic [RegAddrWidth-1:0] shamt_t;
    typedef logic [ImmWidth-1:0]     imm16_t;

    typedef enum logic [3:0] {
        AluZero,
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOp_t;

endpackage

//--- hw/isaPkg.sv
// Integer ALU subset of the MIPS32 encoding only.
// Loads, stores, branches, jumps and multiply/divide are not encoded here.
package isaPkg;

    localparam int NumRegs = 32;
    localparam logic [4:0] ZeroRegAddr = 5'd0;

    // Primary opcode field, bits 31:26
    localparam logic [5:0] OpcodeSpecial = 6'h00;
    localparam logic [5:0] OpcodeAddi    = 6'h08;
    localparam logic [5:0] OpcodeAddiu   = 6'h09;
    localparam logic [5:0] OpcodeSlti    = 6'h0a;
    localparam logic [5:0] OpcodeSltiu   = 6'h0b;
    localparam logic [5:0] OpcodeAndi    = 6'h0c;
    localparam logic [5:0] OpcodeOri     = 6'h0d;
    localparam logic [5:0] OpcodeXori    = 6'h0e;
    localparam logic [5:0] OpcodeLui     = 6'h0f;

    // Funct field for SPECIAL, bits 5:0
    localparam logic [5:0] FunctSll  = 6'h00;
    localparam logic [5:0] FunctSrl  = 6'h02;
    localparam logic [5:0] FunctSra  = 6'h03;
    localparam logic [5:0] FunctSllv = 6'h04;
    localparam logic [5:0] FunctSrlv = 6'h06;
    localparam logic [5:0] FunctSrav = 6'h07;
    localparam logic [5:0] FunctAdd  = 6'h20;
    localparam logic [5:0] FunctAddu = 6'h21;
    localparam logic [5:0] FunctSub  = 6'h22;
    localparam logic [5:0] FunctSubu = 6'h23;
    localparam logic [5:0] FunctAnd  = 6'h24;
    localparam logic [5:0] FunctOr   = 6'h25;
    localparam logic [5:0] FunctXor  = 6'h26;
    localparam logic [5:0] FunctNor  = 6'h27;
    localparam logic [5:0] FunctSlt  = 6'h2a;
    localparam logic [5:0] FunctSltu = 6'h2b;

    typedef enum logic [4:0] {
        InstrNop,
        InstrAdd, InstrAddu, InstrSub, InstrSubu,
        InstrAnd, InstrOr, InstrXor, InstrNor,
        InstrSlt, InstrSltu,
        InstrSll, InstrSrl, InstrSra, InstrSllv, InstrSrlv, InstrSrav,
        InstrAddi, InstrAddiu, InstrAndi, InstrOri, InstrXori,
        InstrSlti, InstrSltiu, InstrLui
    } instrCode_t;

    // I-type forms take the immediate as the B operand
    function automatic logic isImmForm(instrCode_t instr);
        return instr inside {InstrAddi, InstrAddiu, InstrAndi, InstrOri, InstrXori,
                             InstrSlti, InstrSltiu, InstrLui};
    endfunction

    // Logical immediates and LUI zero-extend, everything else sign-extends
    function automatic logic isZeroExt(instrCode_t instr);
        return instr inside {InstrAndi, InstrOri, InstrXori, InstrLui};
    endfunction

    // Shifts by the shamt field rather than by rs
    function automatic logic isShamtShift(instrCode_t instr);
        return instr inside {InstrSll, InstrSrl, InstrSra};
    endfunction

endpackage

//--- hw/regFile.sv
// Register 0 reads as zero; a same-cycle write is visible on both read ports.
`timescale 1ns/100ps

module regFile
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    output word_t    rsData,
    output word_t    rtData
);

    word_t regs [1:NumRegs-1];

    // Zero register, then write-through bypass, then storage
    function automatic word_t readPort(regAddr_t addr, word_t stored, logic wrEn,
                                       regAddr_t wrAddr, word_t wrData);
        if (addr == ZeroRegAddr)
            return '0;
        if (wrEn && wrAddr == addr)
            return wrData;
        return stored;
    endfunction

    always_comb begin
        rsData = readPort(rsAddr, regs[rsAddr], writeEnable, writeAddr, writeData);
        rtData = readPort(rtAddr, regs[rtAddr], writeEnable, writeAddr, writeData);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NumRegs; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != ZeroRegAddr) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

//--- hw/alu.sv
// Purely combinational; ADD/ADDI wrap like ADDU/ADDIU and never trap.
`timescale 1ns/100ps

module alu
    import isaPkg::*;
    import pipePkg::*;
(
    input  instrCode_t instr,
    input  word_t      rsData,
    input  word_t      rtData,
    input  imm16_t     imm,
    input  shamt_t     shamt,
    output word_t      result
);

    aluOp_t aluOp;
    word_t  extImm;
    word_t  srcA;
    word_t  srcB;

    always_comb begin
        case (instr)
            InstrAdd, InstrAddu, InstrAddi, InstrAddiu: aluOp = AluAdd;
            InstrSub, InstrSubu:                        aluOp = AluSub;
            InstrAnd, InstrAndi:                        aluOp = AluAnd;
            InstrOr, InstrOri:                          aluOp = AluOr;
            InstrXor, InstrXori:                        aluOp = AluXor;
            InstrNor:                                   aluOp = AluNor;
            InstrSlt, InstrSlti:                        aluOp = AluSlt;
            InstrSltu, InstrSltiu:                      aluOp = AluSltu;
            InstrSll, InstrSllv:                        aluOp = AluSll;
            InstrSrl, InstrSrlv:                        aluOp = AluSrl;
            InstrSra, InstrSrav:                        aluOp = AluSra;
            InstrLui:                                   aluOp = AluLui;
            default:                                    aluOp = AluZero;
        endcase
    end

    assign extImm = isZeroExt(instr) ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // Shift amount rides on A, the shifted value on B
    assign srcA = isShamtShift(instr) ? {27'd0, shamt} : rsData;
    assign srcB = isImmForm(instr) ? extImm : rtData;

    always_comb begin
        case (aluOp)
            AluAdd:  result = srcA + srcB;
            AluSub:  result = srcA - srcB;
            AluAnd:  result = srcA & srcB;
            AluOr:   result = srcA | srcB;
            AluXor:  result = srcA ^ srcB;
            AluNor:  result = ~(srcA | srcB);
            AluSlt:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            AluSltu: result = {31'd0, srcA < srcB};
            AluSll:  result = srcB << srcA[4:0];
            AluSrl:  result = srcB >> srcA[4:0];
            AluSra:  result = $signed(srcB) >>> srcA[4:0];
            AluLui:  result = {srcB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

//--- hw/decodeStage.sv
// Unsupported words and writes to register 0 leave as bubbles with idValid low.
`timescale 1ns/100ps

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  word_t      instrWord,
    input  logic       instrValid,
    output regAddr_t   rsAddr,
    output regAddr_t   rtAddr,
    input  word_t      rsData,
    input  word_t      rtData,
    output logic       idValid,
    output instrCode_t idInstr,
    output regAddr_t   idRsAddr,
    output regAddr_t   idRtAddr,
    output word_t      idRsData,
    output word_t      idRtData,
    output imm16_t     idImm,
    output shamt_t     idShamt,
    output regAddr_t   idDestAddr
);

    logic [5:0] opcode;
    logic [5:0] funct;
    instrCode_t code;
    regAddr_t   destAddr;
    logic       writes;

    assign opcode = instrWord[31:26];
    assign funct  = instrWord[5:0];

    // Register file is read straight from the incoming word
    assign rsAddr = instrWord[25:21];
    assign rtAddr = instrWord[20:16];

    always_comb begin
        code = InstrNop;
        if (opcode == OpcodeSpecial) begin
            case (funct)
                FunctSll:  code = InstrSll;
                FunctSrl:  code = InstrSrl;
                FunctSra:  code = InstrSra;
                FunctSllv: code = InstrSllv;
                FunctSrlv: code = InstrSrlv;
                FunctSrav: code = InstrSrav;
                FunctAdd:  code = InstrAdd;
                FunctAddu: code = InstrAddu;
                FunctSub:  code = InstrSub;
                FunctSubu: code = InstrSubu;
                FunctAnd:  code = InstrAnd;
                FunctOr:   code = InstrOr;
                FunctXor:  code = InstrXor;
                FunctNor:  code = InstrNor;
                FunctSlt:  code = InstrSlt;
                FunctSltu: code = InstrSltu;
                default:   code = InstrNop;
            endcase
        end else begin
            case (opcode)
                OpcodeAddi:  code = InstrAddi;
                OpcodeAddiu: code = InstrAddiu;
                OpcodeSlti:  code = InstrSlti;
                OpcodeSltiu: code = InstrSltiu;
                OpcodeAndi:  code = InstrAndi;
                OpcodeOri:   code = InstrOri;
                OpcodeXori:  code = InstrXori;
                OpcodeLui:   code = InstrLui;
                default:     code = InstrNop;
            endcase
        end
    end

    // rd for R-type, rt for I-type
    assign destAddr = (code == InstrNop) ? ZeroRegAddr :
                      (opcode == OpcodeSpecial) ? instrWord[15:11] : instrWord[20:16];
    assign writes   = instrValid && (code != InstrNop) && (destAddr != ZeroRegAddr);

    always_ff @(posedge clk) begin
        if (reset) begin
            idValid    <= 1'b0;
            idInstr    <= InstrNop;
            idDestAddr <= ZeroRegAddr;
        end else if (!stall) begin
            idValid    <= writes;
            idInstr    <= writes ? code : InstrNop;
            idDestAddr <= writes ? destAddr : ZeroRegAddr;
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            idRsAddr <= rsAddr;
            idRtAddr <= rtAddr;
            idRsData <= rsData;
            idRtData <= rtData;
            idImm    <= instrWord[15:0];
            idShamt  <= instrWord[10:6];
        end
    end

endmodule

//--- hw/execStage.sv
// Forwarding relies on the MEM and WB sources carrying address 0 when their stage is empty.
`timescale 1ns/100ps

module execStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       idValid,
    input  instrCode_t idInstr,
    input  regAddr_t   idRsAddr,
    input  regAddr_t   idRtAddr,
    input  word_t      idRsData,
    input  word_t      idRtData,
    input  imm16_t     idImm,
    input  shamt_t     idShamt,
    input  regAddr_t   idDestAddr,
    input  regAddr_t   memDestAddr,
    input  word_t      memResult,
    input  regAddr_t   wbDestAddr,
    input  word_t      wbResult,
    output logic       exValid,
    output regAddr_t   exDestAddr,
    output word_t      exResult
);

    word_t rsOperand;
    word_t rtOperand;
    word_t aluResult;

    // Youngest producer wins, register 0 is never forwarded
    function automatic word_t forwardOperand(regAddr_t addr, word_t decoded,
                                             regAddr_t memAddr, word_t memData,
                                             regAddr_t wbAddr, word_t wbData);
        if (addr == ZeroRegAddr)
            return decoded;
        if (addr == memAddr)
            return memData;
        if (addr == wbAddr)
            return wbData;
        return decoded;
    endfunction

    always_comb begin
        rsOperand = forwardOperand(idRsAddr, idRsData, memDestAddr, memResult,
                                   wbDestAddr, wbResult);
        rtOperand = forwardOperand(idRtAddr, idRtData, memDestAddr, memResult,
                                   wbDestAddr, wbResult);
    end

    alu u_alu (
        .instr  (idInstr),
        .rsData (rsOperand),
        .rtData (rtOperand),
        .imm    (idImm),
        .shamt  (idShamt),
        .result (aluResult)
    );

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid    <= 1'b0;
            exDestAddr <= ZeroRegAddr;
        end else if (!stall) begin
            exValid    <= idValid;
            exDestAddr <= idValid ? idDestAddr : ZeroRegAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exResult <= aluResult;
        end
    end

endmodule

//--- hw/writebackStage.sv
// wbValid drops while stalled so a held result is written and shown only once.
`timescale 1ns/100ps

module writebackStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     exValid,
    input  regAddr_t exDestAddr,
    input  word_t    exResult,
    output logic     wbValid,
    output regAddr_t wbDestAddr,
    output word_t    wbResult
);

    logic     validReg;
    regAddr_t destReg;
    word_t    resultReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            validReg  <= 1'b0;
            destReg   <= ZeroRegAddr;
            resultReg <= '0;
        end else if (!stall) begin
            validReg <= exValid;
            // Bubble carries address 0 so nothing forwards from it
            destReg  <= exValid ? exDestAddr : ZeroRegAddr;
            if (exValid)
                resultReg <= exResult;
        end
    end

    assign wbValid    = validReg && !stall;
    assign wbDestAddr = destReg;
    assign wbResult   = resultReg;

endmodule

//--- hw/execCore.sv
// One instruction word per cycle, results three unstalled cycles later.
// A single stall input freezes every stage together.
`timescale 1ns/100ps

module execCore
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  word_t    instrWord,
    input  logic     instrValid,
    output logic     resultValid,
    output regAddr_t resultAddr,
    output word_t    resultData
);

    regAddr_t   rsAddr;
    regAddr_t   rtAddr;
    word_t      rsData;
    word_t      rtData;
    logic       idValid;
    instrCode_t idInstr;
    regAddr_t   idRsAddr;
    regAddr_t   idRtAddr;
    word_t      idRsData;
    word_t      idRtData;
    imm16_t     idImm;
    shamt_t     idShamt;
    regAddr_t   idDestAddr;
    logic       exValid;
    regAddr_t   exDestAddr;
    word_t      exResult;
    logic       wbValid;
    regAddr_t   wbDestAddr;
    word_t      wbResult;

    decodeStage u_decodeStage (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .instrWord  (instrWord),
        .instrValid (instrValid),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rsData     (rsData),
        .rtData     (rtData),
        .idValid    (idValid),
        .idInstr    (idInstr),
        .idRsAddr   (idRsAddr),
        .idRtAddr   (idRtAddr),
        .idRsData   (idRsData),
        .idRtData   (idRtData),
        .idImm      (idImm),
        .idShamt    (idShamt),
        .idDestAddr (idDestAddr)
    );

    regFile u_regFile (
        .clk         (clk),
        .reset       (reset),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .writeEnable (wbValid),
        .writeAddr   (wbDestAddr),
        .writeData   (wbResult),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    // MEM forward source is the stage's own output register
    execStage u_execStage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .idValid     (idValid),
        .idInstr     (idInstr),
        .idRsAddr    (idRsAddr),
        .idRtAddr    (idRtAddr),
        .idRsData    (idRsData),
        .idRtData    (idRtData),
        .idImm       (idImm),
        .idShamt     (idShamt),
        .idDestAddr  (idDestAddr),
        .memDestAddr (exDestAddr),
        .memResult   (exResult),
        .wbDestAddr  (wbDestAddr),
        .wbResult    (wbResult),
        .exValid     (exValid),
        .exDestAddr  (exDestAddr),
        .exResult    (exResult)
    );

    writebackStage u_writebackStage (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .exValid    (exValid),
        .exDestAddr (exDestAddr),
        .exResult   (exResult),
        .wbValid    (wbValid),
        .wbDestAddr (wbDestAddr),
        .wbResult   (wbResult)
    );

    assign resultValid = wbValid;
    assign resultAddr  = wbDestAddr;
    assign resultData  = wbResult;

endmodule

//--- bench/execCore_checker.sv
// Bound into execCore; watches only the result ports and the stall input.
`timescale 1ns/100ps

module execCoreChecker
    import pipePkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     stall,
    input logic     resultValid,
    input regAddr_t resultAddr,
    input word_t    resultData
);

    // Pipeline is empty for two cycles after reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> !resultValid ##1 !resultValid)
        else $error("result appeared within two cycles of reset");

    noZeroDest: assert property (@(posedge clk) disable iff (reset)
        resultValid |-> resultAddr != 5'd0)
        else $error("result shown for register 0");

    // A stalled edge hides the result and leaves the writeback register as it was
    noResultInStall: assert property (@(posedge clk) disable iff (reset)
        stall |-> !resultValid ##1 ($stable(resultAddr) && $stable(resultData)))
        else $error("result shown or changed while stalled");

endmodule

bind execCore execCoreChecker checkerInst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .resultValid (resultValid),
    .resultAddr  (resultAddr),
    .resultData  (resultData)
);

//--- bench/execCoreTb.sv
// Results are expected in issue order; hand rows carry fixed values,
// LFSR rows get theirs from the reference register model at issue time.
`timescale 1ns/100ps

module execCoreTb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int ClkPeriod = 40;
    localparam int NumTests  = 6;

    typedef struct {
        int       testId;
        word_t    word;
        logic     stall;
        logic     hasExpect;
        logic     useModel;
        regAddr_t dest;
        word_t    value;
    } row_t;

    logic     clk;
    logic     reset;
    logic     stall;
    word_t    instrWord;
    logic     instrValid;
    logic     resultValid;
    regAddr_t resultAddr;
    word_t    resultData;

    row_t     rows[$];
    regAddr_t expDest[$];
    word_t    expValue[$];
    int       expEdge[$];
    word_t    refRegs[0:31];
    logic [31:0] lfsrState;
    logic     tableReady;
    int       edgeCount;
    int       checkCount;
    int       errorCount;
    string    testNames[1:NumTests];

    execCore i_execCore (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .instrWord   (instrWord),
        .instrValid  (instrValid),
        .resultValid (resultValid),
        .resultAddr  (resultAddr),
        .resultData  (resultData)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // Unstalled rising edges serve as the time base for result latency
    always @(posedge clk) begin
        if (!stall)
            edgeCount <= edgeCount + 1;
    end

    function automatic word_t encR(logic [5:0] funct, regAddr_t rs, regAddr_t rt,
                                   regAddr_t rd, shamt_t sh);
        return {OpcodeSpecial, rs, rt, rd, sh, funct};
    endfunction

    function automatic word_t encI(logic [5:0] op, regAddr_t rs, regAddr_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    // Galois LFSR stepped once per bit taken
    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsrState[0];
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
    endtask

    // Reference model for the instructions used in generated rows
    task automatic modelExec(input word_t w, output regAddr_t dest, output word_t value);
        word_t a;
        word_t b;
        word_t sext;
        a = refRegs[w[25:21]];
        b = refRegs[w[20:16]];
        sext = {{16{w[15]}}, w[15:0]};
        dest = 5'd0;
        value = '0;
        if (w[31:26] == OpcodeSpecial) begin
            dest = w[15:11];
            case (w[5:0])
                FunctAddu: value = a + b;
                FunctSubu: value = a - b;
                FunctXor:  value = a ^ b;
                FunctSlt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FunctSllv: value = b << a[4:0];
                default:   dest = 5'd0;
            endcase
        end else if (w[31:26] == OpcodeAddiu) begin
            dest = w[20:16];
            value = a + sext;
        end else if (w[31:26] == OpcodeXori) begin
            dest = w[20:16];
            value = a ^ {16'h0000, w[15:0]};
        end
    endtask

    task automatic addRow(input int t, input word_t w, input logic st, input logic ex,
                          input logic um, input regAddr_t d, input word_t v);
        row_t r;
        r.testId = t;
        r.word = w;
        r.stall = st;
        r.hasExpect = ex;
        r.useModel = um;
        r.dest = d;
        r.value = v;
        rows.push_back(r);
    endtask

    task automatic addCheck(input int t, input word_t w, input regAddr_t d, input word_t v);
        addRow(t, w, 1'b0, 1'b1, 1'b0, d, v);
    endtask

    // Dependent row with rs from one back and rt from two or three back
    task automatic addLfsrRow(input int t, input int j);
        logic [31:0] opSel;
        logic [31:0] imm;
        logic [31:0] rtSel;
        regAddr_t d;
        regAddr_t p1;
        regAddr_t p2;
        regAddr_t p3;
        regAddr_t rt;
        word_t w;
        takeBits(3, opSel);
        takeBits(16, imm);
        takeBits(1, rtSel);
        d  = regAddr_t'(26 + j % 4);
        p1 = regAddr_t'(26 + (j + 3) % 4);
        p2 = regAddr_t'(26 + (j + 2) % 4);
        p3 = regAddr_t'(26 + (j + 1) % 4);
        rt = rtSel[0] ? p2 : p3;
        case (opSel[2:0])
            3'd0: w = encR(FunctAddu, p1, rt, d, 5'd0);
            3'd1: w = encR(FunctSubu, p1, rt, d, 5'd0);
            3'd2: w = encR(FunctXor, p1, rt, d, 5'd0);
            3'd3: w = encR(FunctSlt, p1, rt, d, 5'd0);
            3'd4: w = encR(FunctSllv, p1, rt, d, 5'd0);
            3'd5: w = encI(OpcodeAddiu, p1, d, imm[15:0]);
            3'd6: w = encI(OpcodeXori, p3, d, imm[15:0]);
            default: w = encI(OpcodeAddiu, p2, d, imm[15:0]);
        endcase
        addRow(t, w, 1'b0, 1'b0, 1'b1, 5'd0, '0);
    endtask

    task automatic buildTable();
        addCheck(1, encI(OpcodeAddi, 0, 1, 16'hFFFB), 1, 32'hFFFFFFFB);
        addCheck(1, encI(OpcodeAddiu, 0, 2, 16'h1234), 2, 32'h00001234);
        addCheck(1, encI(OpcodeOri, 0, 3, 16'h8001), 3, 32'h00008001);
        addCheck(1, encI(OpcodeAndi, 1, 4, 16'hF0F0), 4, 32'h0000F0F0);
        addCheck(1, encI(OpcodeXori, 2, 5, 16'hFFFF), 5, 32'h0000EDCB);
        addCheck(1, encI(OpcodeLui, 0, 6, 16'hABCD), 6, 32'hABCD0000);
        addCheck(1, encI(OpcodeSlti, 1, 7, 16'hFFFC), 7, 32'h00000001);
        addCheck(1, encI(OpcodeSltiu, 1, 8, 16'h0005), 8, 32'h00000000);
        addCheck(2, encR(FunctAdd, 1, 2, 9, 0), 9, 32'h0000122F);
        addCheck(2, encR(FunctSub, 2, 1, 10, 0), 10, 32'h00001239);
        addCheck(2, encR(FunctAnd, 1, 6, 11, 0), 11, 32'hABCD0000);
        addCheck(2, encR(FunctOr, 3, 2, 12, 0), 12, 32'h00009235);
        addCheck(2, encR(FunctXor, 1, 2, 13, 0), 13, 32'hFFFFEDCF);
        addCheck(2, encR(FunctNor, 3, 0, 14, 0), 14, 32'hFFFF7FFE);
        addCheck(2, encR(FunctSlt, 1, 2, 15, 0), 15, 32'h00000001);
        addCheck(2, encR(FunctSltu, 1, 2, 16, 0), 16, 32'h00000000);
        addCheck(3, encR(FunctSll, 0, 2, 17, 4), 17, 32'h00012340);
        addCheck(3, encR(FunctSrl, 0, 1, 18, 4), 18, 32'h0FFFFFFF);
        addCheck(3, encR(FunctSra, 0, 1, 19, 1), 19, 32'hFFFFFFFD);
        // 35 decimal of which only the low 5 bits (3) shift
        addCheck(3, encI(OpcodeAddi, 0, 20, 16'h0023), 20, 32'h00000023);
        addCheck(3, encR(FunctSllv, 20, 2, 21, 0), 21, 32'h000091A0);
        addCheck(3, encR(FunctSrlv, 20, 6, 22, 0), 22, 32'h1579A000);
        addCheck(3, encR(FunctSrav, 20, 6, 23, 0), 23, 32'hF579A000);
        for (int j = 0; j < 12; j++)
            addLfsrRow(4, j);
        addRow(5, encI(OpcodeAddi, 1, 0, 16'h0007), 1'b0, 1'b0, 1'b0, 0, '0);
        addCheck(5, encR(FunctAdd, 0, 0, 24, 0), 24, 32'h00000000);
        addRow(5, 32'hFC000000, 1'b0, 1'b0, 1'b0, 0, '0);
        addCheck(5, encR(FunctSubu, 0, 2, 25, 0), 25, 32'hFFFFEDCC);
        for (int j = 0; j < 10; j++) begin
            if (j == 4 || j == 7) begin
                addRow(6, encI(OpcodeAddiu, 0, 30, 16'h5555), 1'b1, 1'b0, 1'b0, 0, '0);
                if (j == 4)
                    addRow(6, encI(OpcodeAddiu, 0, 30, 16'h5555), 1'b1, 1'b0, 1'b0, 0, '0);
            end
            addLfsrRow(6, j);
        end
    endtask

    // Called just after a rising edge
    task automatic applyRow(input row_t r);
        regAddr_t d;
        word_t v;
        int due;
        // This edge counts if it was unstalled, then three more edges reach writeback
        due = edgeCount + (stall ? 0 : 1) + 3;
        stall <= r.stall;
        instrWord <= r.word;
        instrValid <= 1'b1;
        if (!r.stall) begin
            if (r.useModel) begin
                modelExec(r.word, d, v);
            end else begin
                d = r.hasExpect ? r.dest : 5'd0;
                v = r.value;
            end
            if (d != 5'd0) begin
                refRegs[d] = v;
                expDest.push_back(d);
                expValue.push_back(v);
                expEdge.push_back(due);
            end
        end
    endtask

    // Result monitor samples mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && resultValid) begin
                if (expDest.size() == 0) begin
                    $display("Unexpected result for register %0d at %0t with no pending entry",
                             resultAddr, $time);
                    errorCount++;
                end else begin
                    checkCount++;
                    if (edgeCount != expEdge[0]) begin
                        $display("Result timing wrong at %0t: %0d edges after issue, expected 3",
                                 $time, edgeCount - expEdge[0] + 3);
                        errorCount++;
                    end
                    if (resultAddr != expDest[0]) begin
                        $display("[ERROR] %0t resultAddr: got %0d, expected %0d",
                                 $time, resultAddr, expDest[0]);
                        errorCount++;
                    end
                    if (resultData != expValue[0]) begin
                        $display("[ERROR] %0t resultData: got %h, expected %h",
                                 $time, resultData, expValue[0]);
                        errorCount++;
                    end
                    void'(expDest.pop_front());
                    void'(expValue.pop_front());
                    void'(expEdge.pop_front());
                end
            end
        end
    end

    initial begin
        wait (tableReady);
        #((rows.size() + NumTests * 8 + 20) * ClkPeriod);
        $display("Timeout: the run did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

    initial begin
        int idx;
        int startChecks;
        int startErrors;
        reset = 1'b1;
        stall = 1'b0;
        instrWord = '0;
        instrValid = 1'b0;
        tableReady = 1'b0;
        edgeCount = 0;
        checkCount = 0;
        errorCount = 0;
        lfsrState = 32'he0bb006a;
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
        testNames[1] = "immediate arithmetic and logic";
        testNames[2] = "register arithmetic and compare";
        testNames[3] = "shifts";
        testNames[4] = "back-to-back dependencies";
        testNames[5] = "register 0 and unsupported words";
        testNames[6] = "stall in dependent sequence";
        buildTable();
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        idx = 0;
        for (int t = 1; t <= NumTests; t++) begin
            startChecks = checkCount;
            startErrors = errorCount;
            while (idx < rows.size() && rows[idx].testId == t) begin
                @(posedge clk);
                applyRow(rows[idx]);
                idx++;
            end
            @(posedge clk);
            instrValid <= 1'b0;
            stall <= 1'b0;
            while (expDest.size() != 0)
                @(negedge clk);
            repeat (3) @(negedge clk);
            $display("Test %0d (%s): %0d checks, %0d errors", t, testNames[t],
                     checkCount - startChecks, errorCount - startErrors);
        end
        $display("Total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- all.f
hw/pipePkg.sv
hw/isaPkg.sv
hw/regFile.sv
hw/alu.sv
hw/decodeStage.sv
hw/execStage.sv
hw/writebackStage.sv
hw/execCore.sv
bench/execCore_checker.sv
bench/execCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the execCore testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module execCoreTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
exit 1
